/* list.f */
src/tape_pkg.sv
src/tap_loader.sv
src/tape_store.sv
src/tape_fetcher.sv
src/tape_top.sv
tb/tb_clock.sv
tb/tape_checker.sv
tb/tb_tape.sv

/* run.sh */
#!/bin/sh
# Build the tape testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tape -f list.f -o sim_tape \
	&& ./obj_dir/sim_tape | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* src/tap_loader.sv */
// Tape loader that writes a host tape download into the tape memory, with host wait control
`timescale 1ns/1ps

module tap_loader import tape_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  host_dl_t          host_i,
	input  logic              ready_i,
	output store_req_t        req_o,
	output logic              wait_o,
	output logic [1:0]        version_o,
	output logic [ADDR_W-1:0] last_addr_o,
	output logic              load_busy_o,
	output logic              load_done_o
);

	logic              tap_sel;
	logic              tap_wr;
	logic              active_q;
	logic              load_start;
	logic              wait_q;
	logic [1:0]        version_q;
	logic [ADDR_W-1:0] last_q;
	logic [ADDR_W-1:0] addr_next;
	logic [ADDR_W-1:0] count_base;
	store_req_t        req_q;

	// Only downloads carrying the tape index are taken
	always_comb begin
		tap_sel    = host_i.download && (host_i.index == TAP_INDEX);
		tap_wr     = tap_sel && host_i.wr;
		load_start = tap_sel && !active_q;
		addr_next  = host_i.addr + ADDR_W'(1);
		// A new tape starts counting from zero
		count_base = load_start ? '0 : last_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Write path and wait control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q  <= 1'b0;
			wait_q    <= 1'b0;
			req_q     <= '0;
			version_q <= 2'b00;
			last_q    <= '0;
		end else begin
			active_q <= tap_sel;
			req_q    <= '0;
			if (load_start) begin
				last_q <= '0;
			end
			if (tap_wr) begin
				req_q.wr   <= 1'b1;
				req_q.addr <= host_i.addr;
				req_q.data <= host_i.data;
				// Hold the host off until the memory has taken the byte
				wait_q     <= 1'b1;
				if (host_i.addr == VERSION_ADDR) begin
					version_q <= host_i.data[1:0];
				end
				if (addr_next > count_base) begin
					last_q <= addr_next;
				end
			end else if (wait_q && !req_q.wr && ready_i) begin
				wait_q <= 1'b0;
			end
		end
	end

	// Falling edge of the tape download ends the load
	assign load_done_o = active_q && !tap_sel;
	assign load_busy_o = tap_sel;

	assign req_o       = req_q;
	assign wait_o      = wait_q;
	assign version_o   = version_q;
	assign last_addr_o = last_q;

endmodule

/* src/tape_fetcher.sv */
// Playback fetcher that reads stored tape bytes in order and pushes them to the tape deck
`timescale 1ns/1ps

module tape_fetcher import tape_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              load_busy_i,
	input  logic              load_done_i,
	input  logic [ADDR_W-1:0] last_addr_i,
	input  logic              autoplay_en_i,
	input  logic              play_toggle_i,
	input  logic              unload_i,
	input  logic              ready_i,
	input  byte_t             rdata_i,
	input  logic              deck_full_i,
	output store_req_t        req_o,
	output byte_t             tap_byte_o,
	output logic              tap_wrreq_o,
	output logic              playing_o,
	output logic              tape_loaded_o
);

	logic [ADDR_W-1:0] play_addr_q;
	logic [ADDR_W-1:0] last_q;
	logic              inflight_q;
	logic              playing_q;
	logic              wrreq_q;
	logic              tape_loaded;
	logic              end_of_tape;
	logic              restart;
	logic              idle_slot;
	logic              deliver;
	byte_t             byte_q;
	store_req_t        req_q;

	always_comb begin
		tape_loaded = play_addr_q < last_q;
		end_of_tape = playing_q && !tape_loaded;
		restart     = reset || load_busy_i || unload_i || end_of_tape;
		// No new step while a read strobe or a delivery is on the wires
		idle_slot   = !req_q.rd && !wrreq_q;
		deliver     = idle_slot && inflight_q && ready_i;
	end

	//////////////////////////////////////////////////////////////////////
	// Tape length and play state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || unload_i) begin
			last_q <= '0;
		end else if (load_done_i) begin
			last_q <= last_addr_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (restart) begin
			playing_q <= 1'b0;
		end else if (load_done_i && autoplay_en_i) begin
			playing_q <= 1'b1;
		end else if (play_toggle_i) begin
			playing_q <= !playing_q;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read and deliver cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (restart) begin
			play_addr_q <= '0;
			inflight_q  <= 1'b0;
			req_q       <= '0;
			wrreq_q     <= 1'b0;
		end else begin
			req_q   <= '0;
			wrreq_q <= 1'b0;
			if (deliver) begin
				wrreq_q     <= 1'b1;
				play_addr_q <= play_addr_q + ADDR_W'(1);
				inflight_q  <= 1'b0;
			end else if (idle_slot && !inflight_q && playing_q && tape_loaded
					&& !deck_full_i) begin
				req_q.rd    <= 1'b1;
				req_q.addr  <= play_addr_q;
				inflight_q  <= 1'b1;
			end
		end
	end

	// Byte for the deck, valid with tap_wrreq_o
	always_ff @(posedge clk_sys) begin
		if (deliver) begin
			byte_q <= rdata_i;
		end
	end

	assign req_o         = req_q;
	assign tap_byte_o    = byte_q;
	assign tap_wrreq_o   = wrreq_q;
	assign playing_o     = playing_q;
	assign tape_loaded_o = tape_loaded;

endmodule

/* src/tape_pkg.sv */
// Shared widths, constants and request types for the tape load and playback path
package tape_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and constants
	//////////////////////////////////////////////////////////////////////

	// Host download address width
	localparam int ADDR_W = 25;

	// Address bits actually backed by the tape memory (1024 bytes)
	localparam int STORE_AW = 10;

	// Host file index of a tape image
	localparam logic [7:0] TAP_INDEX = 8'hC1;

	// Offset of the format version byte in the tape header
	localparam logic [ADDR_W-1:0] VERSION_ADDR = 25'h00000C;

	typedef logic [7:0] byte_t;

	//////////////////////////////////////////////////////////////////////
	// Interface types
	//////////////////////////////////////////////////////////////////////

	// Host download stream, download stays high for the whole file
	typedef struct packed {
		logic              download;
		logic [7:0]        index;
		logic              wr;
		logic [ADDR_W-1:0] addr;
		byte_t             data;
	} host_dl_t;

	// One tape memory request
	// Idle requesters drive all zeros so requests can be ORed together
	typedef struct packed {
		logic              rd;
		logic              wr;
		logic [ADDR_W-1:0] addr;
		byte_t             data;
	} store_req_t;

endpackage

/* src/tape_store.sv */
// Tape image memory that answers every read or write request with a ready pulse
`timescale 1ns/1ps

module tape_store import tape_pkg::*; (
	input  logic       clk_sys,
	input  store_req_t req_i,
	output logic       ready_o,
	output byte_t      rdata_o
);

	localparam int DEPTH = 2 ** STORE_AW;

	byte_t               mem [DEPTH];
	byte_t               rdata_q;
	logic                ready_q;
	logic [STORE_AW-1:0] waddr;

	// Upper address bits are not backed by storage
	assign waddr = req_i.addr[STORE_AW-1:0];

	//////////////////////////////////////////////////////////////////////
	// Memory array
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (req_i.wr) begin
			mem[waddr] <= req_i.data;
		end
		if (req_i.rd) begin
			rdata_q <= mem[waddr];
		end
	end

	// One cycle after any access
	always_ff @(posedge clk_sys) begin
		ready_q <= req_i.rd || req_i.wr;
	end

	assign ready_o = ready_q;
	assign rdata_o = rdata_q;

endmodule

/* src/tape_top.sv */
// Top level of the tape path that joins the loader, the tape memory and the playback fetcher
`timescale 1ns/1ps

module tape_top import tape_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  host_dl_t   host_i,
	output logic       wait_o,
	output logic [1:0] version_o,
	input  logic       autoplay_en_i,
	input  logic       play_toggle_i,
	input  logic       unload_i,
	input  logic       deck_full_i,
	output byte_t      tap_byte_o,
	output logic       tap_wrreq_o,
	output logic       playing_o,
	output logic       tape_loaded_o
);

	store_req_t        load_req;
	store_req_t        fetch_req;
	store_req_t        store_req;
	logic              store_ready;
	byte_t             store_rdata;
	logic [ADDR_W-1:0] last_addr;
	logic              load_busy;
	logic              load_done;

	// Fetcher sits in restart during a tape download, so one side is always idle
	assign store_req = load_req | fetch_req;

	tap_loader u_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host_i      (host_i),
		.ready_i     (store_ready),
		.req_o       (load_req),
		.wait_o      (wait_o),
		.version_o   (version_o),
		.last_addr_o (last_addr),
		.load_busy_o (load_busy),
		.load_done_o (load_done)
	);

	tape_store u_store (
		.clk_sys (clk_sys),
		.req_i   (store_req),
		.ready_o (store_ready),
		.rdata_o (store_rdata)
	);

	tape_fetcher u_fetcher (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_busy_i   (load_busy),
		.load_done_i   (load_done),
		.last_addr_i   (last_addr),
		.autoplay_en_i (autoplay_en_i),
		.play_toggle_i (play_toggle_i),
		.unload_i      (unload_i),
		.ready_i       (store_ready),
		.rdata_i       (store_rdata),
		.deck_full_i   (deck_full_i),
		.req_o         (fetch_req),
		.tap_byte_o    (tap_byte_o),
		.tap_wrreq_o   (tap_wrreq_o),
		.playing_o     (playing_o),
		.tape_loaded_o (tape_loaded_o)
	);

endmodule

/* tb/tape_checker.sv */
// Testbench monitor that models the stored tape from the host stream and checks the DUT ports
`timescale 1ns/1ps

module tape_checker import tape_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  host_dl_t   host_i,
	input  logic       wait_i,
	input  logic [1:0] version_i,
	input  logic       unload_i,
	input  logic       deck_full_i,
	input  byte_t      tap_byte_i,
	input  logic       tap_wrreq_i,
	output int         error_count_o,
	output int         deliver_count_o
);

	byte_t      model_mem [1024];
	int         model_count;
	int         play_ptr;
	int         wait_run;
	int         full_deliveries;
	int         errors;
	int         deliveries;
	logic [1:0] model_version;
	logic       tap_dl;
	logic       tap_wr;
	logic       prev_tap_dl;
	logic       prev_tap_wr;
	logic       prev_dl;

	initial begin
		errors          = 0;
		deliveries      = 0;
		error_count_o   = 0;
		deliver_count_o = 0;
	end

	task automatic fail_value(input string name, input int exp, input int act);
		$display("FAIL %s: expected %0h, actual %0h", name, exp, act);
		errors++;
	endtask

	// Sampled on the falling edge, away from the DUT's register updates
	always @(negedge clk_sys) begin
		tap_dl = host_i.download && (host_i.index == TAP_INDEX);
		tap_wr = tap_dl && host_i.wr;
		if (reset) begin
			model_count     = 0;
			play_ptr        = 0;
			wait_run        = 0;
			full_deliveries = 0;
			model_version   = 2'b00;
			prev_tap_dl     = 1'b0;
			prev_tap_wr     = 1'b0;
			prev_dl         = 1'b0;
		end else begin
			// A new tape download starts from an empty tape
			if (tap_dl && !prev_tap_dl) begin
				model_count = 0;
				play_ptr    = 0;
			end
			if (prev_tap_wr && !wait_i) begin
				fail_value("wait after host write", 1, 0);
			end
			wait_run = wait_i ? wait_run + 1 : 0;
			if (wait_run == 4) begin
				$display("Error: wait_o stayed high for more than three cycles");
				errors++;
			end
			if (host_i.download && host_i.index != TAP_INDEX && wait_i) begin
				$display("Error: wait_o went high during a download that is not a tape");
				errors++;
			end
			if (tap_wr) begin
				model_mem[host_i.addr[9:0]] = host_i.data;
				if (int'(host_i.addr) + 1 > model_count) begin
					model_count = int'(host_i.addr) + 1;
				end
				if (host_i.addr == VERSION_ADDR) begin
					model_version = host_i.data[1:0];
				end
			end
			if (prev_dl && !host_i.download && version_i != model_version) begin
				fail_value("version capture", model_version, version_i);
			end
			if (unload_i) begin
				model_count = 0;
				play_ptr    = 0;
			end
			// Only the read already in flight may land while the deck is full
			if (deck_full_i) begin
				if (tap_wrreq_i) begin
					full_deliveries++;
				end
				if (tap_wrreq_i && full_deliveries > 1) begin
					fail_value("back-pressure deliveries", 1, full_deliveries);
				end
			end else begin
				full_deliveries = 0;
			end
			if (tap_wrreq_i) begin
				deliveries++;
				if (play_ptr >= model_count) begin
					$display("Error: a byte reached the deck while no tape was loaded");
					errors++;
				end else begin
					if (tap_byte_i != model_mem[play_ptr]) begin
						fail_value("playback order", model_mem[play_ptr], tap_byte_i);
					end
					play_ptr++;
					// End of tape rewinds to the start
					if (play_ptr == model_count) begin
						play_ptr = 0;
					end
				end
			end
			prev_tap_dl = tap_dl;
			prev_tap_wr = tap_wr;
			prev_dl     = host_i.download;
		end
		error_count_o   <= errors;
		deliver_count_o <= deliveries;
	end

endmodule

/* tb/tb_clock.sv */
// Testbench clock and reset source, 20 ns period with reset held for the first five cycles
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = !clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

/* tb/tb_tape.sv */
// Testbench top that loads random tapes, plays them back against a random deck and reports
`timescale 1ns/1ps

module tb_tape import tape_pkg::*;;

	logic       clk_sys;
	logic       reset;
	host_dl_t   host;
	logic       autoplay_en;
	logic       play_toggle;
	logic       unload;
	logic       deck_full;
	logic       hold_full;
	logic       wait_o;
	logic [1:0] version_o;
	byte_t      tap_byte_o;
	logic       tap_wrreq_o;
	logic       playing_o;
	logic       tape_loaded_o;
	integer     seed;
	int         len1;
	int         len2;
	int         base;
	int         mark;
	int         tb_errors;
	int         chk_errors;
	int         delivered;
	int         cycles;
	int         cycle_limit = 100000;
	byte_t      file1 [256];
	byte_t      file2 [256];

	tb_clock clk0 (.clk_sys(clk_sys), .reset(reset));

	tape_top dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host_i        (host),
		.wait_o        (wait_o),
		.version_o     (version_o),
		.autoplay_en_i (autoplay_en),
		.play_toggle_i (play_toggle),
		.unload_i      (unload),
		.deck_full_i   (deck_full),
		.tap_byte_o    (tap_byte_o),
		.tap_wrreq_o   (tap_wrreq_o),
		.playing_o     (playing_o),
		.tape_loaded_o (tape_loaded_o)
	);

	tape_checker chk0 (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.host_i          (host),
		.wait_i          (wait_o),
		.version_i       (version_o),
		.unload_i        (unload),
		.deck_full_i     (deck_full),
		.tap_byte_i      (tap_byte_o),
		.tap_wrreq_i     (tap_wrreq_o),
		.error_count_o   (chk_errors),
		.deliver_count_o (delivered)
	);

	// Deck model that is full about a quarter of the time unless held full
	always @(posedge clk_sys) begin
		if (reset) begin
			deck_full <= 1'b0;
		end else if (hold_full) begin
			deck_full <= 1'b1;
		end else begin
			deck_full <= (($random(seed) & 3) == 0);
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_value(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("FAIL %s: expected %0h, actual %0h", name, exp, act);
			tb_errors++;
		end
	endtask

	// Streams one file and sends each byte only while wait_o is low
	task automatic send_file(input logic [7:0] idx, input int len, input int which);
		byte_t d;
		int    i;
		@(posedge clk_sys);
		host.download <= 1'b1;
		host.index    <= idx;
		for (i = 0; i < len; i++) begin
			d = (which == 1) ? file1[i] : (which == 2) ? file2[i] : byte_t'($random(seed));
			@(posedge clk_sys);
			host.wr   <= 1'b1;
			host.addr <= ADDR_W'(i);
			host.data <= d;
			@(posedge clk_sys);
			host.wr <= 1'b0;
			@(negedge clk_sys);
			while (wait_o) @(negedge clk_sys);
		end
		@(posedge clk_sys);
		host.download <= 1'b0;
	endtask

	task automatic pulse_toggle();
		@(posedge clk_sys);
		play_toggle <= 1'b1;
		@(posedge clk_sys);
		play_toggle <= 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic wait_playback(input int total);
		while (delivered < total) @(negedge clk_sys);
		wait_cycles(20);
		check_value("bytes delivered", total, delivered);
		check_value("playing after end of tape", 0, playing_o);
	endtask

	initial begin
		seed        = 53;
		tb_errors   = 0;
		cycles      = 0;
		host        = '0;
		autoplay_en = 1'b0;
		play_toggle = 1'b0;
		unload      = 1'b0;
		hold_full   = 1'b0;
		deck_full   = 1'b0;
		len1 = 20 + (($random(seed) & 32'h7fffffff) % 181);
		len2 = 20 + (($random(seed) & 32'h7fffffff) % 181);
		for (int i = 0; i < 256; i++) begin
			file1[i] = byte_t'($random(seed));
			file2[i] = byte_t'($random(seed));
		end
		// Three loads and three playback passes plus margin for pauses and stalls
		cycle_limit = (3 * len1 + 16 + 2 * len2) * 6 + 2000;
		@(negedge clk_sys);
		while (reset) @(negedge clk_sys);

		//////////////////////////////////////////////////////////////////////
		// Load with autoplay, then a non-tape download
		//////////////////////////////////////////////////////////////////////
		@(posedge clk_sys);
		autoplay_en <= 1'b1;
		send_file(TAP_INDEX, len1, 1);
		wait_playback(len1);
		check_value("version after load", file1[12][1:0], version_o);
		send_file(8'h05, 16, 0);
		wait_cycles(10);
		check_value("loaded after other download", 1, tape_loaded_o);
		check_value("deliveries after other download", len1, delivered);

		//////////////////////////////////////////////////////////////////////
		// Replay with back-pressure and a pause
		//////////////////////////////////////////////////////////////////////
		base = delivered;
		pulse_toggle();
		while (delivered < base + 5) @(negedge clk_sys);
		@(posedge clk_sys);
		hold_full <= 1'b1;
		wait_cycles(2);
		mark = delivered;
		wait_cycles(40);
		if (delivered > mark + 1) begin
			$display("FAIL back-pressure: expected %0h, actual %0h", mark + 1, delivered);
			tb_errors++;
		end
		@(posedge clk_sys);
		hold_full <= 1'b0;
		while (delivered < base + 10) @(negedge clk_sys);
		pulse_toggle();
		wait_cycles(4);
		mark = delivered;
		wait_cycles(40);
		check_value("deliveries while paused", mark, delivered);
		check_value("playing while paused", 0, playing_o);
		pulse_toggle();
		wait_playback(base + len1);

		//////////////////////////////////////////////////////////////////////
		// Unload, then a second tape started by hand
		//////////////////////////////////////////////////////////////////////
		@(posedge clk_sys);
		unload <= 1'b1;
		@(posedge clk_sys);
		unload <= 1'b0;
		wait_cycles(2);
		check_value("loaded after unload", 0, tape_loaded_o);
		mark = delivered;
		pulse_toggle();
		wait_cycles(10);
		pulse_toggle();
		wait_cycles(20);
		check_value("deliveries after unload", mark, delivered);
		@(posedge clk_sys);
		autoplay_en <= 1'b0;
		send_file(TAP_INDEX, len2, 2);
		wait_cycles(10);
		check_value("playing without autoplay", 0, playing_o);
		check_value("loaded after second load", 1, tape_loaded_o);
		check_value("version after second load", file2[12][1:0], version_o);
		base = delivered;
		pulse_toggle();
		wait_playback(base + len2);

		$display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
